/* rv_core_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// data path width, one word
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h8000_0000

// instruction store, in words
`define IMEM_DEPTH 256
`define IMEM_AW 8

// data store, in bytes
`define DMEM_DEPTH 1024
`define DMEM_AW 10

// full ebreak encoding, matched as a whole word
`define EBREAK_INST 32'h0010_0073

`endif

/* rv_core_pkg.sv */
`default_nettype none

`include "rv_core_defs.svh"

package rv_core_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // alu functions
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLTU,
        ALU_NE,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRA
    } alu_op_e;

    // write-back source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,
        WB_IMM
    } wb_sel_e;

    // decoded control word, one per fetched instruction
    typedef struct packed {
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [`XLEN-1:0] imm;
        alu_op_e          alu_op;
        logic             src1_is_pc;
        logic             src2_is_imm;
        logic             reg_wen;
        wb_sel_e          wb_sel;
        logic             is_jal;
        logic             is_jalr;
        logic             is_bne;
        logic             is_ebreak;
        logic             mem_rd;
        logic             mem_wr;
        logic             byte_load;
        logic [3:0]       wmask;
    } ctrl_t;

    // request into the data store
    typedef struct packed {
        logic             rd;
        logic             byte_load;
        logic             wr;
        logic [3:0]       wmask;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

/* inst_decoder.sv */
`default_nettype none

`include "rv_core_defs.svh"

module inst_decoder (
    input  wire logic [`XLEN-1:0] inst,
    output rv_core_pkg::ctrl_t    ctrl
);

    import rv_core_pkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    // raw fields
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // immediates, sign taken from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    // upper immediate has zero low bits
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // all enables low unless a match below
        ctrl        = '0;
        ctrl.rd     = inst[11:7];
        ctrl.rs1    = inst[19:15];
        ctrl.rs2    = inst[24:20];
        ctrl.imm    = imm_i;
        ctrl.alu_op = ALU_ADD;
        ctrl.wb_sel = WB_ALU;

        case (opcode)
            OP_LUI: begin
                // immediate goes straight to rd
                ctrl.imm     = imm_u;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = WB_IMM;
            end
            OP_AUIPC: begin
                ctrl.imm         = imm_u;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_wen     = 1'b1;
            end
            OP_JAL: begin
                ctrl.imm     = imm_j;
                ctrl.is_jal  = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = WB_PC4;
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.is_jalr = 1'b1;
                    ctrl.reg_wen = 1'b1;
                    ctrl.wb_sel  = WB_PC4;
                end
            end
            OP_BRANCH: begin
                // only bne, alu reports rs1 != rs2
                ctrl.imm = imm_b;
                if (funct3 == 3'b001) begin
                    ctrl.is_bne = 1'b1;
                    ctrl.alu_op = ALU_NE;
                end
            end
            OP_LOAD: begin
                // lw or lbu, alu forms the address
                ctrl.src2_is_imm = 1'b1;
                if (funct3 == 3'b010 || funct3 == 3'b100) begin
                    ctrl.mem_rd    = 1'b1;
                    ctrl.byte_load = funct3[2];
                    ctrl.reg_wen   = 1'b1;
                    ctrl.wb_sel    = WB_MEM;
                end
            end
            OP_STORE: begin
                ctrl.imm         = imm_s;
                ctrl.src2_is_imm = 1'b1;
                case (funct3)
                    3'b000: ctrl.wmask = 4'b0001;
                    3'b001: ctrl.wmask = 4'b0011;
                    3'b010: ctrl.wmask = 4'b1111;
                    default: ctrl.wmask = 4'b0000;
                endcase
                ctrl.mem_wr = (ctrl.wmask != 4'b0000);
            end
            OP_IMM: begin
                ctrl.src2_is_imm = 1'b1;
                if (funct3 == 3'b000) begin
                    ctrl.reg_wen = 1'b1;
                end else if (funct3 == 3'b011) begin
                    // sltiu compares against the sign-extended imm
                    ctrl.alu_op  = ALU_SLTU;
                    ctrl.reg_wen = 1'b1;
                end else if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
                    ctrl.alu_op  = ALU_SRA;
                    ctrl.reg_wen = 1'b1;
                end
            end
            OP_REG: begin
                ctrl.reg_wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.alu_op = ALU_SUB;
                    {7'b0000000, 3'b001}: ctrl.alu_op = ALU_SLL;
                    {7'b0000000, 3'b011}: ctrl.alu_op = ALU_SLTU;
                    {7'b0000000, 3'b100}: ctrl.alu_op = ALU_XOR;
                    {7'b0000000, 3'b110}: ctrl.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_wen = 1'b0;
                endcase
            end
            OP_SYSTEM: begin
                // ecall and csr ops fall through as no-ops
                ctrl.is_ebreak = (inst == `EBREAK_INST);
            end
            default: begin
                ctrl.reg_wen = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* reg_file.sv */
`default_nettype none

`include "rv_core_defs.svh"

module reg_file (
    input  wire logic             clk,
    input  wire logic             wen,
    input  wire logic [4:0]       waddr,
    input  wire logic [`XLEN-1:0] wdata,
    input  wire logic [4:0]       raddr1,
    input  wire logic [4:0]       raddr2,
    input  wire logic [4:0]       dbg_addr,
    output      logic [`XLEN-1:0] rdata1,
    output      logic [`XLEN-1:0] rdata2,
    output      logic [`XLEN-1:0] dbg_data
);

    // x1..x31 live here, x0 entry is never written
    logic [`XLEN-1:0] regs [32];

    // write on the edge, x0 dropped
    always_ff @(posedge clk) begin
        if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads of the stored state
    // x0 forced to zero on every port
    assign rdata1   = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2   = (raddr2 == 5'd0) ? '0 : regs[raddr2];
    // debug port for the testbench
    assign dbg_data = (dbg_addr == 5'd0) ? '0 : regs[dbg_addr];

endmodule

`default_nettype wire

/* alu.sv */
`default_nettype none

`include "rv_core_defs.svh"

module alu (
    input  wire logic [`XLEN-1:0] src1,
    input  wire logic [`XLEN-1:0] src2,
    input  wire rv_core_pkg::alu_op_e alu_op,
    output      logic [`XLEN-1:0] result
);

    import rv_core_pkg::*;

    logic [4:0] shamt;

    // shift amount from low five bits only
    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD: result = src1 + src2;
            ALU_SUB: result = src1 - src2;
            // unsigned compare, 0 or 1
            ALU_SLTU: begin
                result = {{(`XLEN-1){1'b0}}, (src1 < src2)};
            end
            // used by bne to decide the branch
            ALU_NE: begin
                result = {{(`XLEN-1){1'b0}}, (src1 != src2)};
            end
            ALU_XOR: result = src1 ^ src2;
            ALU_OR:  result = src1 | src2;
            ALU_AND: result = src1 & src2;
            ALU_SLL: result = src1 << shamt;
            // arithmetic shift keeps the sign
            ALU_SRA: result = $unsigned($signed(src1) >>> shamt);
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* inst_mem.sv */
`default_nettype none

`include "rv_core_defs.svh"

module inst_mem (
    input  wire logic                clk,
    input  wire logic                we,
    input  wire logic [`IMEM_AW-1:0] waddr,
    input  wire logic [`XLEN-1:0]    wdata,
    input  wire logic [`IMEM_AW-1:0] raddr,
    output      logic [`XLEN-1:0]    rdata
);

    // program words, filled over the load port
    logic [`XLEN-1:0] mem [`IMEM_DEPTH];

    // one word per cycle while loading
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // fetch is combinational
    // instruction ready in the same cycle as pc
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* data_mem.sv */
`default_nettype none

`include "rv_core_defs.svh"

module data_mem (
    input  wire logic             clk,
    input  wire rv_core_pkg::dmem_req_t req,
    output      logic [`XLEN-1:0] rdata
);

    // little-endian byte store
    logic [7:0]          mem [`DMEM_DEPTH];
    logic [`DMEM_AW-1:0] lane_addr [4];
    logic [`XLEN-1:0]    word_data;

    // byte address per lane, wraps at the top
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_addr[i] = req.addr[`DMEM_AW-1:0] + `DMEM_AW'(i);
        end
    end

    // masked write, lane i lands at addr + i
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (req.wr && req.wmask[i]) begin
                mem[lane_addr[i]] <= req.wdata[8*i +: 8];
            end
        end
    end

    // word view starting at addr
    assign word_data = {mem[lane_addr[3]], mem[lane_addr[2]],
                        mem[lane_addr[1]], mem[lane_addr[0]]};

    // zero when no load
    // lbu keeps only the byte at addr
    always_comb begin
        if (!req.rd) begin
            rdata = '0;
        end else if (req.byte_load) begin
            rdata = {{(`XLEN-8){1'b0}}, word_data[7:0]};
        end else begin
            rdata = word_data;
        end
    end

endmodule

`default_nettype wire

/* rv_core.sv */
`default_nettype none

`include "rv_core_defs.svh"

module rv_core (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                imem_we,
    input  wire logic [`IMEM_AW-1:0] imem_addr,
    input  wire logic [`XLEN-1:0]    imem_wdata,
    input  wire logic [4:0]          dbg_addr,
    output      logic [`XLEN-1:0]    dbg_data,
    output      logic [`XLEN-1:0]    pc,
    output      logic [`XLEN-1:0]    alu_result,
    output      logic                halted
);

    import rv_core_pkg::*;

    logic [`XLEN-1:0]    fetch_offset;
    logic [`IMEM_AW-1:0] fetch_index;
    logic [`XLEN-1:0]    inst;
    ctrl_t               ctrl;
    logic [`XLEN-1:0]    rs1_val;
    logic [`XLEN-1:0]    rs2_val;
    logic [`XLEN-1:0]    alu_src1;
    logic [`XLEN-1:0]    alu_src2;
    logic [`XLEN-1:0]    eff_addr;
    dmem_req_t           dmem_req;
    logic [`XLEN-1:0]    mem_rdata;
    logic [`XLEN-1:0]    pc_plus4;
    logic [`XLEN-1:0]    wb_data;
    logic                reg_wen;
    logic                bne_taken;
    logic [`XLEN-1:0]    next_pc;

    // word index relative to the reset pc
    assign fetch_offset = pc - `RESET_PC;
    assign fetch_index  = fetch_offset[`IMEM_AW+1:2];

    inst_mem u_inst_mem (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_addr),
        .wdata (imem_wdata),
        .raddr (fetch_index),
        .rdata (inst)
    );

    inst_decoder u_inst_decoder (
        .inst (inst),
        .ctrl (ctrl)
    );

    // no register writes once halted
    assign reg_wen = ctrl.reg_wen && !halted;

    reg_file u_reg_file (
        .clk      (clk),
        .wen      (reg_wen),
        .waddr    (ctrl.rd),
        .wdata    (wb_data),
        .raddr1   (ctrl.rs1),
        .raddr2   (ctrl.rs2),
        .dbg_addr (dbg_addr),
        .rdata1   (rs1_val),
        .rdata2   (rs2_val),
        .dbg_data (dbg_data)
    );

    // operand muxes
    assign alu_src1 = ctrl.src1_is_pc ? pc : rs1_val;
    assign alu_src2 = ctrl.src2_is_imm ? ctrl.imm : rs2_val;

    alu u_alu (
        .src1   (alu_src1),
        .src2   (alu_src2),
        .alu_op (ctrl.alu_op),
        .result (alu_result)
    );

    // rs1 + imm, shared by loads, stores and jalr
    assign eff_addr = rs1_val + ctrl.imm;

    // memory request, both strobes off while halted
    assign dmem_req.rd        = ctrl.mem_rd && !halted;
    assign dmem_req.byte_load = ctrl.byte_load;
    assign dmem_req.wr        = ctrl.mem_wr && !halted;
    assign dmem_req.wmask     = ctrl.wmask;
    assign dmem_req.addr      = eff_addr;
    assign dmem_req.wdata     = rs2_val;

    data_mem u_data_mem (
        .clk   (clk),
        .req   (dmem_req),
        .rdata (mem_rdata)
    );

    assign pc_plus4 = pc + 32'd4;

    // write-back source
    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = mem_rdata;
            WB_PC4:  wb_data = pc_plus4;
            WB_IMM:  wb_data = ctrl.imm;
            default: wb_data = alu_result;
        endcase
    end

    // alu gives 1 when rs1 != rs2
    assign bne_taken = ctrl.is_bne && alu_result[0];

    // jalr first, then pc-relative jumps, else fall through
    always_comb begin
        if (ctrl.is_jalr) begin
            next_pc = eff_addr & ~32'd1;
        end else if (ctrl.is_jal || bne_taken) begin
            next_pc = pc + ctrl.imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // pc and halt flag
    // ebreak edge sets halted and pc stays on the ebreak
    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            if (ctrl.is_ebreak) begin
                halted <= 1'b1;
            end else begin
                pc <= next_pc;
            end
        end
    end

endmodule

`default_nettype wire

/* rv_core_tb.sv */
`default_nettype none

`include "rv_core_defs.svh"

module rv_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_core_pkg::*;

    // program layout
    localparam int PROG_LEN   = 35;
    localparam int EBREAK_IDX = 34;
    // 22 straight-line, 3 loop passes of 3, then 8 up to and incl. ebreak
    localparam int RETIRED    = 39;
    localparam int NUM_CHECKS = 23;
    localparam int HALT_LIMIT = 200;

    // register index with the value it must hold at the end
    typedef struct packed {
        logic [4:0]       idx;
        logic [`XLEN-1:0] value;
    } reg_entry_t;

    logic                clk;
    logic                reset;
    logic                imem_we;
    logic [`IMEM_AW-1:0] imem_addr;
    logic [`XLEN-1:0]    imem_wdata;
    logic [4:0]          dbg_addr;
    logic [`XLEN-1:0]    dbg_data;
    logic [`XLEN-1:0]    pc;
    logic [`XLEN-1:0]    alu_result;
    logic                halted;

    logic [`XLEN-1:0] prog [PROG_LEN];
    reg_entry_t       reg_table [NUM_CHECKS];
    int               cycles;
    int               pc_idx;

    rv_core uut (
        .clk        (clk),
        .reset      (reset),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .dbg_addr   (dbg_addr),
        .dbg_data   (dbg_data),
        .pc         (pc),
        .alu_result (alu_result),
        .halted     (halted)
    );

    // 4 ns period
    initial clk = 1'b0;
    always #2 clk = ~clk;

    // instruction formats
    function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type(opcode_e op, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, int imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(logic [2:0] f3, logic [4:0] rs2,
                                           logic [4:0] rs1, int imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    // branch offset in bytes, bit 0 dropped
    function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1,
                                           logic [4:0] rs2, int imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(opcode_e op, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(logic [4:0] rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // program words and the register values they must leave behind
    task automatic build_tables();
        // alu and immediates, x1 = -5, x2 = 3
        prog[0]  = i_type(OP_IMM, 3'b000, 1, 0, -5);
        prog[1]  = i_type(OP_IMM, 3'b000, 2, 0, 3);
        prog[2]  = r_type(7'b0000000, 3'b000, 3, 1, 2);
        prog[3]  = r_type(7'b0100000, 3'b000, 4, 1, 2);
        prog[4]  = r_type(7'b0000000, 3'b100, 5, 1, 2);
        prog[5]  = r_type(7'b0000000, 3'b110, 6, 1, 2);
        prog[6]  = r_type(7'b0000000, 3'b111, 7, 1, 2);
        prog[7]  = r_type(7'b0000000, 3'b001, 8, 2, 2);
        prog[8]  = r_type(7'b0000000, 3'b011, 9, 2, 1);
        prog[9]  = i_type(OP_IMM, 3'b011, 10, 1, -1);
        // srai, funct7 sits in the top of the immediate
        prog[10] = i_type(OP_IMM, 3'b101, 11, 1, 12'h401);
        prog[11] = u_type(OP_LUI, 12, 20'h12345);
        prog[12] = u_type(OP_AUIPC, 13, 20'h00001);
        // stores overlap at bytes 16..19, then read back
        prog[13] = u_type(OP_LUI, 14, 20'h11223);
        prog[14] = i_type(OP_IMM, 3'b000, 14, 14, 12'h344);
        prog[15] = s_type(3'b010, 14, 0, 16);
        prog[16] = s_type(3'b001, 1, 0, 17);
        prog[17] = s_type(3'b000, 2, 0, 19);
        prog[18] = i_type(OP_LOAD, 3'b010, 15, 0, 16);
        prog[19] = i_type(OP_LOAD, 3'b100, 16, 0, 17);
        // countdown loop, x18 gains 2 per pass
        prog[20] = i_type(OP_IMM, 3'b000, 17, 0, 3);
        prog[21] = i_type(OP_IMM, 3'b000, 18, 0, 0);
        prog[22] = i_type(OP_IMM, 3'b000, 18, 18, 2);
        prog[23] = i_type(OP_IMM, 3'b000, 17, 17, -1);
        prog[24] = b_type(3'b001, 17, 0, -8);
        // jumps, each skips one write to x20
        prog[25] = i_type(OP_IMM, 3'b000, 20, 0, 7);
        prog[26] = j_type(19, 8);
        prog[27] = i_type(OP_IMM, 3'b000, 20, 0, 99);
        prog[28] = u_type(OP_AUIPC, 21, 20'h00000);
        prog[29] = i_type(OP_JALR, 3'b000, 22, 21, 12);
        prog[30] = i_type(OP_IMM, 3'b000, 20, 0, 55);
        // x0 write, then mul and slti which are not in the subset
        prog[31] = i_type(OP_IMM, 3'b000, 0, 0, 9);
        prog[32] = r_type(7'b0000001, 3'b000, 20, 1, 2);
        prog[33] = i_type(OP_IMM, 3'b010, 20, 1, 1);
        prog[34] = `EBREAK_INST;

        reg_table[0]  = '{5'd0, 32'd0};
        reg_table[1]  = '{5'd1, -32'sd5};
        reg_table[2]  = '{5'd2, 32'd3};
        reg_table[3]  = '{5'd3, -32'sd5 + 32'sd3};
        reg_table[4]  = '{5'd4, -32'sd5 - 32'sd3};
        reg_table[5]  = '{5'd5, 32'hFFFF_FFFB ^ 32'd3};
        reg_table[6]  = '{5'd6, 32'hFFFF_FFFB | 32'd3};
        reg_table[7]  = '{5'd7, 32'hFFFF_FFFB & 32'd3};
        reg_table[8]  = '{5'd8, 32'd3 << 3};
        reg_table[9]  = '{5'd9, 32'd1};
        reg_table[10] = '{5'd10, 32'd1};
        // -5 shifted right by one, rounding toward minus infinity
        reg_table[11] = '{5'd11, -32'sd3};
        reg_table[12] = '{5'd12, 32'h1234_5000};
        reg_table[13] = '{5'd13, `RESET_PC + 32'd48 + 32'h1000};
        reg_table[14] = '{5'd14, 32'h1122_3344};
        // byte 16 from sw, 17..18 from sh, 19 from sb
        reg_table[15] = '{5'd15, {8'h03, 8'hFF, 8'hFB, 8'h44}};
        reg_table[16] = '{5'd16, 32'h0000_00FB};
        reg_table[17] = '{5'd17, 32'd0};
        reg_table[18] = '{5'd18, 32'd6};
        reg_table[19] = '{5'd19, `RESET_PC + 32'd27 * 4};
        reg_table[20] = '{5'd20, 32'd7};
        reg_table[21] = '{5'd21, `RESET_PC + 32'd28 * 4};
        reg_table[22] = '{5'd22, `RESET_PC + 32'd30 * 4};
    endtask

    // stops the run on the first mismatch
    task automatic check_value(string what, logic [`XLEN-1:0] got, logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s read %h, expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        reset      = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        dbg_addr   = '0;
        cycles     = 0;
        pc_idx     = 0;
        build_tables();

        // load one word per cycle while reset is high
        @(posedge clk);
        #1;
        for (int i = 0; i < PROG_LEN; i++) begin
            imem_we    = 1'b1;
            imem_addr  = `IMEM_AW'(i);
            imem_wdata = prog[i];
            @(posedge clk);
            #1;
        end
        imem_we = 1'b0;

        // three more reset cycles after the load
        repeat (3) begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;

        // one instruction retires per edge
        while (!halted) begin
            // first thirteen words each write rd = index + 1
            // alu output must already hold that value, lui excluded
            pc_idx = int'((pc - `RESET_PC) >> 2);
            if (pc_idx <= 12 && pc_idx != 11) begin
                check_value($sformatf("alu_result at word %0d", pc_idx), alu_result,
                            reg_table[pc_idx + 1].value);
            end
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > HALT_LIMIT) begin
                $display("core never halted within %0d cycles", HALT_LIMIT);
                $display("Test FAILED");
                $fatal(1, "halt timeout");
            end
        end
        check_value("cycles to halt", cycles, RETIRED);
        check_value("pc at halt", pc, `RESET_PC + 32'(EBREAK_IDX * 4));

        // pc frozen on the ebreak
        repeat (5) begin
            @(posedge clk);
        end
        #1;
        check_value("pc after halt", pc, `RESET_PC + 32'(EBREAK_IDX * 4));
        check_value("halted", {31'd0, halted}, 32'd1);

        // walk the register table through the debug port
        for (int i = 0; i < NUM_CHECKS; i++) begin
            @(posedge clk);
            #1;
            dbg_addr = reg_table[i].idx;
            #1;
            check_value($sformatf("x%0d", reg_table[i].idx), dbg_data, reg_table[i].value);
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_core.f */
+incdir+.
rv_core_pkg.sv
inst_decoder.sv
reg_file.sv
alu.sv
inst_mem.sv
data_mem.sv
rv_core.sv
rv_core_tb.sv
